// ==== run.sh ====
#!/bin/sh
# build and run the tcb testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary -Wno-fatal -f verilog.f --top-module tcb_tb -o tcb_sim \
  && ./obj_dir/tcb_sim | tee /dev/stderr | grep "^TEST PASSED$" > /dev/null \
  && echo "simulation run ok" \
  || { echo "simulation run failed"; exit 1; }

// ==== tcb_lib_decoder.sv ====
// tcb address decoder, one manager to two subordinates
// routes requests by address bit 9, muxes the response a cycle later

`timescale 1ns/100ps

`include "tcb_params.svh"

module tcb_lib_decoder (
  input  logic           man,
  input  logic           reset,
  // upstream side
  input  logic           sub_vld,
  input  tcb_pkg::req_t  sub_req,
  output tcb_pkg::rsp_t  sub_rsp,
  // region 0 subordinate
  output logic           man0_vld,
  output tcb_pkg::req_t  man0_req,
  input  tcb_pkg::rsp_t  man0_rsp,
  // region 1 subordinate
  output logic           man1_vld,
  output tcb_pkg::req_t  man1_req,
  input  tcb_pkg::rsp_t  man1_rsp
);

  ////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////

  // top address bit is the region select
  logic          region;
  tcb_pkg::req_t fwd_req;

  assign region = sub_req.adr[`TCB_ADR_W-1];

  // forwarded request, region bit stripped
  always_comb
  begin
    fwd_req = sub_req;
    fwd_req.adr[`TCB_ADR_W-1] = 1'b0;
  end

  ////////////////////////////////////////////////////////////
  // request routing
  ////////////////////////////////////////////////////////////

  // vld reaches exactly one subordinate
  assign man0_vld = sub_vld & ~region;
  assign man1_vld = sub_vld &  region;

  // payload goes to both, only the selected one acts on it
  assign man0_req = fwd_req;
  assign man1_req = fwd_req;

  ////////////////////////////////////////////////////////////
  // response select
  ////////////////////////////////////////////////////////////

  logic sel_q;

  // region of the last transfer, delay 1 to match the memories
  // on idle cycles the last answering memory stays selected
  always_ff @(posedge man)
  begin
    if (reset)
    begin
      sel_q <= 1'b0;
    end
    else if (sub_vld)
    begin
      sel_q <= region;
    end
  end

  // response mux
  assign sub_rsp = sel_q ? man1_rsp : man0_rsp;

endmodule

// ==== tcb_lib_register_response.sv ====
// tcb register slice on the response path
// request passes through, response gets one extra register stage

`timescale 1ns/100ps

module tcb_lib_register_response (
  input  logic           man,
  input  logic           reset,
  // upstream side, manager connects here
  input  logic           sub_vld,
  input  tcb_pkg::req_t  sub_req,
  output tcb_pkg::rsp_t  sub_rsp,
  // downstream side, subordinate connects here
  output logic           man_vld,
  output tcb_pkg::req_t  man_req,
  input  tcb_pkg::rsp_t  man_rsp
);

  ////////////////////////////////////////////////////////////
  // request path
  ////////////////////////////////////////////////////////////

  // no request stage, straight through
  assign man_vld = sub_vld;
  assign man_req = sub_req;

  ////////////////////////////////////////////////////////////
  // read flag
  ////////////////////////////////////////////////////////////

  logic rd_q;

  // marks the downstream response of the next cycle
  always_ff @(posedge man)
  begin
    if (reset)
    begin
      rd_q <= 1'b0;
    end
    else
    begin
      rd_q <= sub_vld & ~sub_req.wen;
    end
  end

  ////////////////////////////////////////////////////////////
  // response register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge man)
  begin
    if (reset)
    begin
      sub_rsp <= '0;
    end
    else
    begin
      // status every cycle
      sub_rsp.sts <= man_rsp.sts;
      // read data only behind a read, else hold the last read
      if (rd_q)
      begin
        sub_rsp.rdt <= man_rsp.rdt;
      end
    end
  end

endmodule

// ==== tcb_mem_sub.sv ====
// tcb memory subordinate with byte enables
// one cycle response, error status for words past the end

`timescale 1ns/100ps

`include "tcb_params.svh"

module tcb_mem_sub #(
  // log2 of word count
  parameter int depth_log = 8
)(
  input  logic           man,
  input  logic           reset,
  input  logic           vld,
  input  tcb_pkg::req_t  req,
  output tcb_pkg::rsp_t  rsp
);

  ////////////////////////////////////////////////////////////
  // address check
  ////////////////////////////////////////////////////////////

  logic [depth_log-1:0] idx;
  logic                 oor;

  // low bits index the array
  assign idx = req.adr[depth_log-1:0];

  // any upper bit set is past the end
  assign oor = (req.adr >> depth_log) != '0;

  ////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////

  logic [`TCB_DAT_W-1:0] mem [0:2**depth_log-1];

  // byte enabled write, out of range writes dropped
  always_ff @(posedge man)
  begin
    if (vld & req.wen & ~oor)
    begin
      for (int i = 0; i < `TCB_BEN_W; i++)
      begin
        if (req.ben[i])
        begin
          mem[idx][8*i +: 8] <= req.wdt[8*i +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // response register
  ////////////////////////////////////////////////////////////

  // updated on transfers only, idle cycles hold the last one
  always_ff @(posedge man)
  begin
    if (reset)
    begin
      rsp <= '0;
    end
    else if (vld)
    begin
      // error, no data
      if (oor)
      begin
        rsp.rdt <= '0;
        rsp.sts <= 1'b1;
      end
      // write returns zero data
      else if (req.wen)
      begin
        rsp.rdt <= '0;
        rsp.sts <= 1'b0;
      end
      // read sees the word before this edge's write
      else
      begin
        rsp.rdt <= mem[idx];
        rsp.sts <= 1'b0;
      end
    end
  end

endmodule

// ==== tcb_params.svh ====
// tightly coupled bus parameters
// bus widths and memory depths shared by the package and the RTL

`ifndef TCB_PARAMS_SVH
`define TCB_PARAMS_SVH

////////////////////////////////////////////////////////////
// bus widths
////////////////////////////////////////////////////////////

// word address, bit 9 picks the region
`define TCB_ADR_W 10
`define TCB_DAT_W 32
// one enable per data byte
`define TCB_BEN_W 4

////////////////////////////////////////////////////////////
// memory depths, log2 of word count
////////////////////////////////////////////////////////////

`define TCB_MEM0_DEPTH_LOG 8
`define TCB_MEM1_DEPTH_LOG 6

`endif

// ==== tcb_pkg.sv ====
// tightly coupled bus types
// request and response payloads as packed structs

`include "tcb_params.svh"

package tcb_pkg;

  ////////////////////////////////////////////////////////////
  // request, driven by the manager side
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    // write enable, low means read
    logic                   wen;
    // byte enables
    logic [`TCB_BEN_W-1:0]  ben;
    // word address
    logic [`TCB_ADR_W-1:0]  adr;
    // write data
    logic [`TCB_DAT_W-1:0]  wdt;
  } req_t;

  ////////////////////////////////////////////////////////////
  // response, driven by the subordinate side
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    // read data
    logic [`TCB_DAT_W-1:0]  rdt;
    // error status, high on out of range
    logic                   sts;
  } rsp_t;

endpackage

// ==== tcb_tb.sv ====
// tcb subsystem testbench
// directed and lfsr traffic checked against a reference model

`timescale 1ns/100ps

`include "tcb_params.svh"

module tcb_tb;

  localparam int reset_cycles = 8;
  localparam int test_cycles  = 700;
  localparam int clk_period   = 20;

  // expected response, rdt_known low while the data is undefined
  typedef struct packed {
    logic          rdt_known;
    tcb_pkg::rsp_t rsp;
  } exp_t;

  // queued transfer, tagged with the cycle it was driven
  typedef struct packed {
    logic [31:0] cyc;
    exp_t        e;
  } entry_t;

  logic          man;
  logic          reset;
  logic          vld;
  tcb_pkg::req_t req;
  tcb_pkg::rsp_t rsp;

  int     cyc;
  int     errors;
  int     checks;
  entry_t pend [$];
  entry_t cmp_ent;

  logic [31:0] lfsr_state;

  // model state, one known flag per byte
  logic [`TCB_DAT_W-1:0] mdl0 [0:(1<<`TCB_MEM0_DEPTH_LOG)-1];
  logic [`TCB_BEN_W-1:0] kn0  [0:(1<<`TCB_MEM0_DEPTH_LOG)-1];
  logic [`TCB_DAT_W-1:0] mdl1 [0:(1<<`TCB_MEM1_DEPTH_LOG)-1];
  logic [`TCB_BEN_W-1:0] kn1  [0:(1<<`TCB_MEM1_DEPTH_LOG)-1];
  logic [`TCB_DAT_W-1:0] last_rdt;
  logic                  last_known;
  logic                  last_sts;

  tcb_tb_clk #(.period (clk_period)) i_clk (.man (man));

  tcb_top i_dut (
    .man (man), .reset (reset), .vld (vld), .req (req), .rsp (rsp)
  );

  ////////////////////////////////////////////////////////////
  // lfsr, x^32 + x^22 + x^2 + x + 1
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  // steps the model by one cycle, returns the top response two cycles on
  function automatic exp_t model_step(input logic v, input tcb_pkg::req_t r);
    exp_t        e;
    logic        region;
    logic        oor;
    logic [7:0]  word0;
    logic [5:0]  word1;
    word0  = r.adr[7:0];
    word1  = r.adr[5:0];
    region = r.adr[`TCB_ADR_W-1];
    // region 0 has 256 words, region 1 has 64
    oor    = region ? (r.adr[8:6] != 3'b000) : r.adr[8];
    if (v)
    begin
      // status follows every transfer
      last_sts = oor;
      if (!r.wen)
      begin
        // reads load rdt, zero when out of range
        last_rdt   = oor ? '0 : (region ? mdl1[word1] : mdl0[word0]);
        last_known = oor | (region ? (&kn1[word1]) : (&kn0[word0]));
      end
      else if (!oor)
      begin
        for (int i = 0; i < `TCB_BEN_W; i++)
        begin
          if (r.ben[i] && region)
          begin
            mdl1[word1][8*i +: 8] = r.wdt[8*i +: 8];
            kn1[word1][i] = 1'b1;
          end
          else if (r.ben[i])
          begin
            mdl0[word0][8*i +: 8] = r.wdt[8*i +: 8];
            kn0[word0][i] = 1'b1;
          end
        end
      end
    end
    // writes and idles keep the last read data
    e.rdt_known = last_known;
    e.rsp.rdt   = last_rdt;
    e.rsp.sts   = last_sts;
    return e;
  endfunction

  ////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////

  // one cycle of traffic, queued with its expected response
  task automatic drive(input logic v, input tcb_pkg::req_t r);
    entry_t ent;
    @(posedge man);
    cyc = cyc + 1;
    vld <= v;
    req <= r;
    ent.cyc = cyc;
    ent.e   = model_step(v, r);
    pend.push_back(ent);
  endtask

  task automatic write_word(input logic [9:0] a, input logic [3:0] b, input logic [31:0] d);
    tcb_pkg::req_t r;
    r.wen = 1'b1;
    r.ben = b;
    r.adr = a;
    r.wdt = d;
    drive(1'b1, r);
  endtask

  task automatic read_word(input logic [9:0] a);
    tcb_pkg::req_t r;
    r.wen = 1'b0;
    r.ben = 4'hf;
    r.adr = a;
    r.wdt = '0;
    drive(1'b1, r);
  endtask

  task automatic idle(input int n);
    repeat (n) drive(1'b0, '0);
  endtask

  // pattern built from every address bit
  function automatic logic [31:0] fill_word(input logic [9:0] a);
    return {a, 6'h2d, ~a, 6'h12};
  endfunction

  task automatic random_traffic(input int n);
    tcb_pkg::req_t r;
    logic [31:0]   kind;
    logic [31:0]   region;
    logic [31:0]   word;
    logic [31:0]   oor;
    logic [31:0]   upper;
    logic [31:0]   ben;
    for (int t = 0; t < n; t++)
    begin
      kind   = take_bits(2);
      region = take_bits(1);
      word   = take_bits(4);
      oor    = take_bits(3);
      upper  = take_bits(3);
      ben    = take_bits(4);
      // 0 idle, 1 write, 2 and 3 read
      r.wen = (kind[1:0] == 2'd1);
      r.ben = ben[3:0];
      r.adr = {region[0], 5'b00000, word[3:0]};
      r.wdt = take_bits(32);
      // about one in eight goes past the end
      if (oor[2:0] == 3'b000 && region[0])
      begin
        r.adr[8:6] = upper[2:0] | 3'b001;
      end
      else if (oor[2:0] == 3'b000)
      begin
        r.adr[8] = 1'b1;
      end
      drive(kind[1:0] != 2'd0, r);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // compare, at the falling edge where rsp is stable
  ////////////////////////////////////////////////////////////

  always @(negedge man)
  begin
    if (pend.size() > 0 && pend[0].cyc + 2 == cyc)
    begin
      cmp_ent = pend.pop_front();
      checks  = checks + 1;
      if (rsp.sts !== cmp_ent.e.rsp.sts)
      begin
        errors = errors + 1;
        $display("[ERROR] rsp.sts got %h expected %h, cycle %0d",
                 rsp.sts, cmp_ent.e.rsp.sts, cmp_ent.cyc);
      end
      // undefined words are not compared
      if (cmp_ent.e.rdt_known && rsp.rdt !== cmp_ent.e.rsp.rdt)
      begin
        errors = errors + 1;
        $display("[ERROR] rsp.rdt got %h expected %h, cycle %0d",
                 rsp.rdt, cmp_ent.e.rsp.rdt, cmp_ent.cyc);
      end
    end
  end

  // watchdog, test length plus half again
  initial
  begin
    #((reset_cycles + test_cycles) * clk_period * 3 / 2);
    $display("timeout, the tests did not finish in the expected time");
    $display("TEST FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    logic [9:0] a;
    vld        = 1'b0;
    req        = '0;
    reset      = 1'b1;
    cyc        = 0;
    errors     = 0;
    checks     = 0;
    lfsr_state = 32'hadb4;
    last_rdt   = '0;
    last_known = 1'b1;
    last_sts   = 1'b0;
    for (int i = 0; i < (1 << `TCB_MEM0_DEPTH_LOG); i++)
    begin
      kn0[i] = '0;
    end
    for (int i = 0; i < (1 << `TCB_MEM1_DEPTH_LOG); i++)
    begin
      kn1[i] = '0;
    end
    repeat (reset_cycles) @(posedge man);
    reset <= 1'b0;

    // zero response out of reset
    idle(3);
    @(negedge man);
    if (rsp !== '0)
    begin
      errors = errors + 1;
      $display("[ERROR] rsp got %h expected %h after reset", rsp, 33'h0);
    end

    // full words in region 0
    for (int i = 0; i < 8; i++)
    begin
      write_word(10'(i), 4'hf, fill_word(10'(i)));
    end
    write_word(10'h0ff, 4'hf, fill_word(10'h0ff));
    for (int i = 0; i < 8; i++)
    begin
      read_word(10'(i));
    end
    read_word(10'h0ff);

    // byte enables
    write_word(10'h020, 4'hf, 32'h11223344);
    write_word(10'h020, 4'b0101, 32'haabbccdd);
    read_word(10'h020);
    write_word(10'h021, 4'hf, 32'h55667788);
    write_word(10'h021, 4'b1000, 32'h99000000);
    idle(1);
    read_word(10'h021);

    // same low bits, separate regions
    write_word(10'h005, 4'hf, 32'hcafe0005);
    write_word(10'h205, 4'hf, 32'hbeef0205);
    read_word(10'h005);
    read_word(10'h205);

    // past the end of each region, then check the aliased words
    read_word(10'h100);
    read_word(10'h240);
    write_word(10'h105, 4'hf, 32'hdead0105);
    write_word(10'h245, 4'hf, 32'hdead0245);
    read_word(10'h005);
    read_word(10'h205);

    // prefill the random window
    for (int i = 0; i < 16; i++)
    begin
      a = 10'(i);
      write_word(a, 4'hf, fill_word(a));
      a[9] = 1'b1;
      write_word(a, 4'hf, fill_word(a));
    end
    random_traffic(600);

    // let the last responses arrive
    while (pend.size() > 0)
    begin
      @(posedge man);
      cyc = cyc + 1;
      vld <= 1'b0;
      @(negedge man);
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
    begin
      $display("TEST PASSED");
    end
    else
    begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== tcb_tb_clk.sv ====
// testbench clock generator
// free running clock for the tcb testbench

`timescale 1ns/100ps

module tcb_tb_clk #(
  // clock period in ns
  parameter int period = 20
)(
  output logic man
);

  // starts low, first rising edge at half a period
  initial
  begin
    man = 1'b0;
    forever #(period / 2) man = ~man;
  end

endmodule

// ==== tcb_top.sv ====
// tcb subsystem top
// response slice, address decoder and two memory regions

`timescale 1ns/100ps

`include "tcb_params.svh"

module tcb_top (
  input  logic           man,
  input  logic           reset,
  input  logic           vld,
  input  tcb_pkg::req_t  req,
  output tcb_pkg::rsp_t  rsp
);

  ////////////////////////////////////////////////////////////
  // internal links
  ////////////////////////////////////////////////////////////

  // slice to decoder
  logic          dec_vld;
  tcb_pkg::req_t dec_req;
  tcb_pkg::rsp_t dec_rsp;
  // decoder to memories
  logic          m0_vld;
  logic          m1_vld;
  tcb_pkg::req_t m0_req;
  tcb_pkg::req_t m1_req;
  tcb_pkg::rsp_t m0_rsp;
  tcb_pkg::rsp_t m1_rsp;

  // extra response stage, total delay 2
  tcb_lib_register_response u_slice (
    .man (man), .reset (reset),
    .sub_vld (vld), .sub_req (req), .sub_rsp (rsp),
    .man_vld (dec_vld), .man_req (dec_req), .man_rsp (dec_rsp)
  );

  tcb_lib_decoder u_dec (
    .man (man), .reset (reset),
    .sub_vld (dec_vld), .sub_req (dec_req), .sub_rsp (dec_rsp),
    .man0_vld (m0_vld), .man0_req (m0_req), .man0_rsp (m0_rsp),
    .man1_vld (m1_vld), .man1_req (m1_req), .man1_rsp (m1_rsp)
  );

  // region 0, 256 words
  tcb_mem_sub #(.depth_log (`TCB_MEM0_DEPTH_LOG)) u_mem0 (
    .man (man), .reset (reset), .vld (m0_vld), .req (m0_req), .rsp (m0_rsp)
  );

  // region 1, 64 words
  tcb_mem_sub #(.depth_log (`TCB_MEM1_DEPTH_LOG)) u_mem1 (
    .man (man), .reset (reset), .vld (m1_vld), .req (m1_req), .rsp (m1_rsp)
  );

endmodule

// ==== verilog.f ====
+incdir+.
tcb_pkg.sv
tcb_lib_register_response.sv
tcb_lib_decoder.sv
tcb_mem_sub.sv
tcb_top.sv
tcb_tb_clk.sv
tcb_tb.sv
